//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := spi_target_tb
FILELIST := sim.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := Simulation PASSED

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/spi_async_fifo.sv
module spi_async_fifo (
   input  logic                       wr_clk_i,
   input  logic                       wr_en_i,
   input  logic [spi_pkg::BYTE_W-1:0] wr_data_i,
   output logic                       full_o,
   input  logic                       rd_clk_i,
   input  logic                       rd_en_i,
   output logic [spi_pkg::BYTE_W-1:0] rd_data_o,
   output logic                       empty_o,
   input  logic                       SSEL
);

   // Entry storage
   logic [spi_pkg::BYTE_W-1:0] mem [0:spi_pkg::FIFO_DEPTH-1];

   // Pointers carry one extra wrap bit
   logic [spi_pkg::FIFO_AW:0] wr_bin, wr_bin_nxt, wr_gray;
   logic [spi_pkg::FIFO_AW:0] rd_bin, rd_bin_nxt, rd_gray;
   // Read pointer seen from the write side
   logic [spi_pkg::FIFO_AW:0] rd_gray_w1, rd_gray_w2;
   // Write pointer seen from the read side
   logic [spi_pkg::FIFO_AW:0] wr_gray_r1, wr_gray_r2;

   // ------------------------------
   // Write side
   // ------------------------------
   assign wr_bin_nxt = wr_bin + 1'b1;

   always_ff @(posedge wr_clk_i) begin
      if (wr_en_i && !full_o) begin
         mem[wr_bin[spi_pkg::FIFO_AW-1:0]] <= wr_data_i;
      end
   end

   always_ff @(posedge wr_clk_i or posedge SSEL) begin
      if (SSEL) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_w1 <= '0;
         rd_gray_w2 <= '0;
      end else begin
         rd_gray_w1 <= rd_gray;
         rd_gray_w2 <= rd_gray_w1;
         if (wr_en_i && !full_o) begin
            wr_bin  <= wr_bin_nxt;
            wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
         end
      end
   end

   // Full when Gray pointers differ only in the two top bits
   // A stale read pointer can only make this pessimistic
   assign full_o = (wr_gray == {~rd_gray_w2[spi_pkg::FIFO_AW:spi_pkg::FIFO_AW-1],
                                rd_gray_w2[spi_pkg::FIFO_AW-2:0]});

   // ------------------------------
   // Read side
   // ------------------------------
   assign rd_bin_nxt = rd_bin + 1'b1;

   always_ff @(posedge rd_clk_i or posedge SSEL) begin
      if (SSEL) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
      end else begin
         wr_gray_r1 <= wr_gray;
         wr_gray_r2 <= wr_gray_r1;
         if (rd_en_i && !empty_o) begin
            rd_bin  <= rd_bin_nxt;
            rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
         end
      end
   end

   // Head entry is visible without a read strobe
   assign rd_data_o = mem[rd_bin[spi_pkg::FIFO_AW-1:0]];
   assign empty_o   = (rd_gray == wr_gray_r2);

   // Producers must respect the flags themselves
   a_no_push_full: assert property (@(posedge wr_clk_i) disable iff (SSEL)
      wr_en_i |-> !full_o);
   a_no_pop_empty: assert property (@(posedge rd_clk_i) disable iff (SSEL)
      rd_en_i |-> !empty_o);

endmodule

//--- hw/spi_bus_master.sv
module spi_bus_master (
   input  logic                       clk_i,
   input  logic                       SSEL,
   output logic                       cyc_o,
   output logic                       stb_o,
   output logic                       we_o,
   output logic [spi_pkg::BYTE_W-1:0] dat_o,
   input  logic                       ack_i,
   input  logic [spi_pkg::BYTE_W-1:0] rx_data_i,
   input  logic                       rx_empty_i,
   output logic                       rx_pull_o,
   input  logic                       tx_full_i,
   output logic                       tx_push_o,
   output logic [spi_pkg::BYTE_W-1:0] tx_data_o,
   input  logic [spi_pkg::BYTE_W-1:0] dat_i
);

   // Select synchroniser stages
   logic       sel_meta;
   logic       sel_q;
   // Bus state
   logic [1:0] state_q;
   logic       start_wr;
   logic       start_rd;

   // ------------------------------
   // Select synchroniser
   // ------------------------------
   // Falls at once on SSEL, rises two edges later
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         sel_meta <= 1'b0;
         sel_q    <= 1'b0;
      end else begin
         sel_meta <= 1'b1;
         sel_q    <= sel_meta;
      end
   end

   // Cycle frames the whole SPI transaction
   assign cyc_o = sel_q;

   // ------------------------------
   // Bus FSM
   // ------------------------------
   // Received data goes out before any prefetch
   assign start_wr = sel_q && (state_q == spi_pkg::BUS_IDLE) && !rx_empty_i;
   // Prefetch only while there is room for the answer
   assign start_rd = sel_q && (state_q == spi_pkg::BUS_IDLE) && rx_empty_i &&
                     !tx_full_i;

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         state_q <= spi_pkg::BUS_IDLE;
      end else begin
         case (state_q)
            spi_pkg::BUS_IDLE: begin
               if (start_wr) begin
                  state_q <= spi_pkg::BUS_WRITE;
               end else if (start_rd) begin
                  state_q <= spi_pkg::BUS_READ;
               end
            end
            // Hold until the slave answers
            spi_pkg::BUS_WRITE, spi_pkg::BUS_READ: begin
               if (ack_i) begin
                  state_q <= spi_pkg::BUS_IDLE;
               end
            end
            default: begin
               state_q <= spi_pkg::BUS_IDLE;
            end
         endcase
      end
   end

   // Strobe and direction follow the state directly
   assign stb_o = (state_q != spi_pkg::BUS_IDLE);
   assign we_o  = (state_q == spi_pkg::BUS_WRITE);

   // Write data is taken from the FIFO head as the cycle starts
   always_ff @(posedge clk_i) begin
      if (start_wr) begin
         dat_o <= rx_data_i;
      end
   end

   assign rx_pull_o = start_wr;

   // Read data is valid with the acknowledge
   assign tx_push_o = (state_q == spi_pkg::BUS_READ) && ack_i;
   assign tx_data_o = dat_i;

   // Strobe only inside a framed cycle
   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (SSEL)
      stb_o |-> cyc_o);
   // Direction must not change while the slave is stalling
   a_we_stable: assert property (@(posedge clk_i) disable iff (SSEL)
      stb_o && !ack_i |=> stb_o && $stable(we_o));

endmodule

//--- hw/spi_pkg.sv
package spi_pkg;

   // ------------------------------
   // Widths and sizes
   // ------------------------------
   // Serial byte, also the bus data width
   localparam int BYTE_W = 8;

   // Both FIFOs share one geometry
   localparam int FIFO_AW    = 2;
   localparam int FIFO_DEPTH = 1 << FIFO_AW;

   // ------------------------------
   // Fixed MISO bytes
   // ------------------------------
   // First byte of every transaction
   localparam logic [BYTE_W-1:0] HEADER_BYTE = 8'hA7;
   // Sent when no prefetched byte is ready
   localparam logic [BYTE_W-1:0] FILL_BYTE   = 8'hFF;

   // Bus master state codes
   localparam logic [1:0] BUS_IDLE  = 2'd0;
   localparam logic [1:0] BUS_WRITE = 2'd1;
   localparam logic [1:0] BUS_READ  = 2'd2;

endpackage

//--- hw/spi_shift_engine.sv
module spi_shift_engine (
   input  logic                       sck_i,
   input  logic                       SSEL,
   input  logic                       mosi_i,
   output logic                       miso_o,
   output logic [spi_pkg::BYTE_W-1:0] rx_data_o,
   output logic                       rx_push_o,
   input  logic                       rx_full_i,
   input  logic [spi_pkg::BYTE_W-1:0] tx_data_i,
   input  logic                       tx_empty_i,
   output logic                       tx_pull_o,
   output logic                       overflow_o,
   output logic                       underrun_o
);

   // Receive shifter holds the first seven bits of a byte
   logic [spi_pkg::BYTE_W-2:0]         rx_sr;
   logic [$clog2(spi_pkg::BYTE_W)-1:0] rx_cnt;
   logic                               rx_last;
   // Transmit shifter holds the bits still to go after miso_o
   logic [spi_pkg::BYTE_W-2:0]         tx_sr;
   logic [$clog2(spi_pkg::BYTE_W)-1:0] tx_cnt;
   logic                               tx_last;
   logic [spi_pkg::BYTE_W-1:0]         tx_byte;

   // ------------------------------
   // Capture on rising sck
   // ------------------------------
   always_ff @(posedge sck_i) begin
      rx_sr <= {rx_sr[spi_pkg::BYTE_W-3:0], mosi_i};
   end

   // Bit counter wraps at the byte boundary
   assign rx_last = &rx_cnt;

   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         rx_cnt     <= '0;
         overflow_o <= 1'b0;
      end else begin
         rx_cnt <= rx_cnt + 1'b1;
         // Sticky until deselect
         if (rx_last && rx_full_i) begin
            overflow_o <= 1'b1;
         end
      end
   end

   // Eighth bit joins the byte straight from the pin
   assign rx_data_o = {rx_sr, mosi_i};
   // Byte is dropped when the FIFO has no room
   assign rx_push_o = rx_last && !rx_full_i;

   // ------------------------------
   // Launch on falling sck
   // ------------------------------
   assign tx_last   = &tx_cnt;
   assign tx_byte   = tx_empty_i ? spi_pkg::FILL_BYTE : tx_data_i;
   // Pop happens on the same edge that loads the head
   assign tx_pull_o = tx_last && !tx_empty_i;

   always_ff @(negedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         tx_cnt     <= '0;
         tx_sr      <= spi_pkg::HEADER_BYTE[spi_pkg::BYTE_W-2:0];
         miso_o     <= spi_pkg::HEADER_BYTE[spi_pkg::BYTE_W-1];
         underrun_o <= 1'b0;
      end else begin
         tx_cnt <= tx_cnt + 1'b1;
         if (tx_last) begin
            // Next byte, MSB first
            miso_o <= tx_byte[spi_pkg::BYTE_W-1];
            tx_sr  <= tx_byte[spi_pkg::BYTE_W-2:0];
            if (tx_empty_i) begin
               underrun_o <= 1'b1;
            end
         end else begin
            miso_o <= tx_sr[spi_pkg::BYTE_W-2];
            tx_sr  <= {tx_sr[spi_pkg::BYTE_W-3:0], 1'b0};
         end
      end
   end

   // Master samples here, so the line must be clean whatever the FIFO holds
   a_miso_known: assert property (@(posedge sck_i) disable iff (SSEL)
      !$isunknown(miso_o));

endmodule

//--- hw/spi_target.sv
module spi_target (
   input  logic                       clk_i,
   input  logic                       SSEL,
   input  logic                       sck_i,
   input  logic                       mosi_i,
   input  logic                       ack_i,
   input  logic [spi_pkg::BYTE_W-1:0] dat_i,
   output logic                       miso_o,
   output logic                       cyc_o,
   output logic                       stb_o,
   output logic                       we_o,
   output logic [spi_pkg::BYTE_W-1:0] dat_o,
   output logic                       overflow_o,
   output logic                       underrun_o
);

   // Receive path, serial clock to clk_i
   logic [spi_pkg::BYTE_W-1:0] rx_wdata, rx_head;
   logic                       rx_push, rx_full, rx_pull, rx_empty;
   // Transmit path, clk_i to serial clock
   logic [spi_pkg::BYTE_W-1:0] tx_wdata, tx_head;
   logic                       tx_push, tx_full, tx_pull, tx_empty;
   // Transmit FIFO pops on the launch edge
   logic                       sck_n;

   assign sck_n = ~sck_i;

   // ------------------------------
   // Serial domain
   // ------------------------------
   spi_shift_engine engine (
      .sck_i     (sck_i),
      .SSEL      (SSEL),
      .mosi_i    (mosi_i),
      .miso_o    (miso_o),
      .rx_data_o (rx_wdata),
      .rx_push_o (rx_push),
      .rx_full_i (rx_full),
      .tx_data_i (tx_head),
      .tx_empty_i(tx_empty),
      .tx_pull_o (tx_pull),
      .overflow_o(overflow_o),
      .underrun_o(underrun_o)
   );

   spi_async_fifo rx_fifo (
      .wr_clk_i (sck_i),
      .wr_en_i  (rx_push),
      .wr_data_i(rx_wdata),
      .full_o   (rx_full),
      .rd_clk_i (clk_i),
      .rd_en_i  (rx_pull),
      .rd_data_o(rx_head),
      .empty_o  (rx_empty),
      .SSEL     (SSEL)
   );

   spi_async_fifo tx_fifo (
      .wr_clk_i (clk_i),
      .wr_en_i  (tx_push),
      .wr_data_i(tx_wdata),
      .full_o   (tx_full),
      .rd_clk_i (sck_n),
      .rd_en_i  (tx_pull),
      .rd_data_o(tx_head),
      .empty_o  (tx_empty),
      .SSEL     (SSEL)
   );

   // ------------------------------
   // Bus domain
   // ------------------------------
   spi_bus_master bus (
      .clk_i     (clk_i),
      .SSEL      (SSEL),
      .cyc_o     (cyc_o),
      .stb_o     (stb_o),
      .we_o      (we_o),
      .dat_o     (dat_o),
      .ack_i     (ack_i),
      .rx_data_i (rx_head),
      .rx_empty_i(rx_empty),
      .rx_pull_o (rx_pull),
      .tx_full_i (tx_full),
      .tx_push_o (tx_push),
      .tx_data_o (tx_wdata),
      .dat_i     (dat_i)
   );

endmodule

//--- sim.f
hw/spi_pkg.sv
hw/spi_async_fifo.sv
hw/spi_shift_engine.sv
hw/spi_bus_master.sv
hw/spi_target.sv
testbench/spi_bus_model.sv
testbench/spi_target_tb.sv

//--- testbench/spi_bus_model.sv
module spi_bus_model (
   input  logic                       clk_i,
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [spi_pkg::BYTE_W-1:0] dat_i,
   input  logic                       ack_enable_i,
   output logic                       ack_o,
   output logic [spi_pkg::BYTE_W-1:0] dat_o
);

   // Traffic of the current transaction, oldest first
   logic [spi_pkg::BYTE_W-1:0] wr_log[$];
   logic [spi_pkg::BYTE_W-1:0] rd_log[$];

   // Cycles still to wait before the next acknowledge
   logic [1:0]  wait_cnt;
   logic        cyc_q;
   logic [31:0] rnd;

   initial begin
      ack_o    = 1'b0;
      dat_o    = '0;
      wait_cnt = 2'd0;
      cyc_q    = 1'b0;
   end

   always @(posedge clk_i) begin
      cyc_q <= cyc_i;
      // New frame, so drop the old logs
      if (cyc_i && !cyc_q) begin
         wr_log.delete();
         rd_log.delete();
      end
      if (ack_o) begin
         // The cycle completes at this edge
         ack_o <= 1'b0;
         if (stb_i && we_i) begin
            wr_log.push_back(dat_i);
         end else if (stb_i) begin
            rd_log.push_back(dat_o);
         end
      end else if (stb_i && ack_enable_i) begin
         if (wait_cnt == 2'd0) begin
            rnd = $urandom;
            ack_o <= 1'b1;
            // Read data rides with the acknowledge
            dat_o <= rnd[spi_pkg::BYTE_W-1:0];
            // Next answer comes after 1 to 3 cycles
            rnd = $urandom;
            wait_cnt <= 2'(rnd % 3);
         end else begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

endmodule

//--- testbench/spi_target_tb.sv
module spi_target_tb;

   // Half an sck period in clk_i cycles so that sck runs at clk_i / 8
   localparam int HALF_SCK = 4;
   localparam int WAIT_MAX = 200;
   localparam int QUIET    = 8;

   logic                       clk_i, SSEL, sck_i, mosi_i, ack_i, ack_enable;
   logic [spi_pkg::BYTE_W-1:0] dat_i, dat_o;
   logic                       miso_o, cyc_o, stb_o, we_o, overflow_o, underrun_o;

   // Bytes sent and received in the current transaction
   logic [spi_pkg::BYTE_W-1:0] mosi_q[$];
   logic [spi_pkg::BYTE_W-1:0] miso_q[$];

   spi_target UUT (
      .clk_i(clk_i), .SSEL(SSEL), .sck_i(sck_i), .mosi_i(mosi_i),
      .ack_i(ack_i), .dat_i(dat_i), .miso_o(miso_o), .cyc_o(cyc_o),
      .stb_o(stb_o), .we_o(we_o), .dat_o(dat_o),
      .overflow_o(overflow_o), .underrun_o(underrun_o)
   );

   spi_bus_model bus_model (
      .clk_i(clk_i), .cyc_i(cyc_o), .stb_i(stb_o), .we_i(we_o), .dat_i(dat_o),
      .ack_enable_i(ack_enable), .ack_o(ack_i), .dat_o(dat_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // ------------------------------
   // Checking
   // ------------------------------
   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic timed_out(input string what);
      $display("timeout: %s", what);
      $display("Simulation FAILED");
      $fatal(1, "wait timed out");
   endtask

   // Bus counts as idle once stb_o stays low for a while
   task automatic wait_bus_quiet();
      int n;
      int quiet;
      n = 0;
      quiet = 0;
      while (quiet < QUIET) begin
         if (n == WAIT_MAX) timed_out("bus never went idle");
         @(negedge clk_i);
         n++;
         quiet = stb_o ? 0 : quiet + 1;
      end
      @(posedge clk_i);
   endtask

   // ------------------------------
   // SPI master
   // ------------------------------
   task automatic spi_select();
      int n;
      mosi_q.delete();
      miso_q.delete();
      SSEL <= 1'b0;
      n = 0;
      while (!cyc_o) begin
         if (n == WAIT_MAX) timed_out("cyc_o did not rise after select");
         @(negedge clk_i);
         n++;
      end
      @(posedge clk_i);
   endtask

   // Mode 0 with MOSI set up on the falling edge and MISO taken on the rising edge
   task automatic spi_byte(input logic [spi_pkg::BYTE_W-1:0] tx,
                           output logic [spi_pkg::BYTE_W-1:0] rx);
      for (int i = spi_pkg::BYTE_W - 1; i >= 0; i--) begin
         mosi_i <= tx[i];
         repeat (HALF_SCK) @(posedge clk_i);
         rx[i] = miso_o;
         sck_i <= 1'b1;
         repeat (HALF_SCK) @(posedge clk_i);
         sck_i <= 1'b0;
      end
   endtask

   task automatic spi_transfer(input int count);
      logic [31:0]                rnd;
      logic [spi_pkg::BYTE_W-1:0] rx;
      for (int k = 0; k < count; k++) begin
         rnd = $urandom;
         mosi_q.push_back(rnd[spi_pkg::BYTE_W-1:0]);
         spi_byte(rnd[spi_pkg::BYTE_W-1:0], rx);
         miso_q.push_back(rx);
      end
   endtask

   task automatic spi_deselect();
      wait_bus_quiet();
      SSEL <= 1'b1;
      repeat (2) @(posedge clk_i);
   endtask

   // Written bytes must match MOSI in order and in number
   task automatic compare_writes(input string name, input int count);
      check({name, " write count"}, 32'(count), 32'(bus_model.wr_log.size()));
      for (int k = 0; k < count; k++) begin
         check({name, " write data"}, 32'(mosi_q[k]), 32'(bus_model.wr_log[k]));
      end
   endtask

   // MISO byte k carries read k-1 once the header is out
   task automatic compare_reads(input string name);
      check({name, " miso header"}, 32'(spi_pkg::HEADER_BYTE), 32'(miso_q[0]));
      check({name, " read count"}, 32'd1,
            32'(bus_model.rd_log.size() >= miso_q.size() - 1));
      for (int k = 1; k < miso_q.size(); k++) begin
         check({name, " miso data"}, 32'(bus_model.rd_log[k-1]), 32'(miso_q[k]));
      end
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic test_idle();
      check("idle cyc_o", 32'd0, 32'(cyc_o));
      check("idle stb_o", 32'd0, 32'(stb_o));
      check("idle we_o", 32'd0, 32'(we_o));
      check("idle overflow_o", 32'd0, 32'(overflow_o));
      check("idle underrun_o", 32'd0, 32'(underrun_o));
      check("idle miso_o", 32'(spi_pkg::HEADER_BYTE[spi_pkg::BYTE_W-1]), 32'(miso_o));
   endtask

   task automatic test_header();
      spi_select();
      spi_transfer(1);
      spi_deselect();
      check("header miso", 32'(spi_pkg::HEADER_BYTE), 32'(miso_q[0]));
      compare_writes("header", 1);
   endtask

   task automatic test_streaming();
      spi_select();
      spi_transfer(8);
      wait_bus_quiet();
      check("stream overflow_o", 32'd0, 32'(overflow_o));
      check("stream underrun_o", 32'd0, 32'(underrun_o));
      spi_deselect();
      compare_writes("stream", 8);
      compare_reads("stream");
   endtask

   // Slave withholds ack so receive fills and transmit runs dry
   task automatic test_stall();
      ack_enable <= 1'b0;
      spi_select();
      spi_transfer(spi_pkg::FIFO_DEPTH);
      check("stall overflow_o early", 32'd0, 32'(overflow_o));
      spi_transfer(1);
      check("stall overflow_o", 32'd1, 32'(overflow_o));
      spi_transfer(1);
      check("stall underrun_o", 32'd1, 32'(underrun_o));
      for (int k = 1; k <= spi_pkg::FIFO_DEPTH + 1; k++) begin
         check("stall miso fill", 32'(spi_pkg::FILL_BYTE), 32'(miso_q[k]));
      end
      ack_enable <= 1'b1;
      wait_bus_quiet();
      compare_writes("stall", spi_pkg::FIFO_DEPTH);
   endtask

   // Runs straight after the stall while the target is still selected
   task automatic test_deselect();
      spi_deselect();
      check("deselect overflow_o", 32'd0, 32'(overflow_o));
      check("deselect underrun_o", 32'd0, 32'(underrun_o));
      check("deselect cyc_o", 32'd0, 32'(cyc_o));
      spi_select();
      spi_transfer(3);
      wait_bus_quiet();
      check("reselect overflow_o", 32'd0, 32'(overflow_o));
      check("reselect underrun_o", 32'd0, 32'(underrun_o));
      spi_deselect();
      compare_writes("reselect", 3);
      compare_reads("reselect");
   endtask

   initial begin
      void'($urandom(97));
      SSEL       = 1'b1;
      sck_i      = 1'b0;
      mosi_i     = 1'b0;
      ack_enable = 1'b1;
      repeat (2) @(posedge clk_i);
      test_idle();
      test_header();
      test_streaming();
      test_stall();
      test_deselect();
      $display("Simulation PASSED");
      $finish;
   end

endmodule
